//--- verilog/ql_bus_pkg.sv
package ql_bus_pkg;

  // ====================================================================
  // CPU bus cycle as seen by the peripheral block
  // ====================================================================
  typedef struct packed {
    logic        vma;    // Valid memory address
    logic        rw;     // High for read
    logic        uds_n;  // Upper strobe for even byte
    logic        lds_n;  // Lower strobe for odd byte
    logic [6:1]  addr;   // Word address inside $18000 block
    logic [15:0] wdata;  // Data from CPU
  } cpu_bus_t;

  // ====================================================================
  // Decoded selects and write strobes
  // ====================================================================
  typedef struct packed {
    logic timer_rd;   // Read $18000-$18003
    logic timer_clr;  // Write $18000
    logic timer_adj;  // Write $18001
    logic ipc_wr;     // Write $18003
    logic irq_rd;     // Read $18020/21
    logic irq_wr;     // Write $18021
    logic mode_wr;    // Write $18063
  } port_sel_t;

  // Port word addresses as bits 6 to 1
  localparam logic [6:1] PORT_TIMER   = 6'd0;   // $18000
  localparam logic [6:1] PORT_IPC_WR  = 6'd1;   // $18002/03
  localparam logic [6:1] PORT_IPC_IRQ = 6'd16;  // $18020/21
  localparam logic [6:1] PORT_DISPLAY = 6'd49;  // $18062/63

endpackage

//--- verilog/ql_ipc_pkg.sv
package ql_ipc_pkg;

  // ====================================================================
  // IPC commands and engine states
  // ====================================================================
  typedef enum logic [3:0] {
    CMD_STATUS    = 4'd1,   // Get status
    CMD_READ_KEY  = 4'd8,   // Read key
    CMD_KEY_ROW   = 4'd9,   // Read key row
    CMD_SET_SOUND = 4'd10   // Set sound
  } ipc_cmd_e;

  typedef enum logic [1:0] {
    IPC_IDLE  = 2'd0,  // Collecting command bits
    IPC_SEND  = 2'd1,  // Shifting reply out
    IPC_PARAM = 2'd2,  // Collecting row number
    IPC_SOUND = 2'd3   // Collecting sound bits
  } ipc_state_e;

  localparam logic [3:0] KEY_TAG    = 4'b0001;  // Key report marker
  localparam int         SOUND_BITS = 64;

  // Key report as QDOS expects it
  typedef struct packed {
    logic [3:0] tag;
    logic       zero_a;
    logic       shift;
    logic       ctrl;
    logic       alt;
    logic [1:0] zero_b;
    logic [2:0] row_n;  // Row inverted
    logic [2:0] col;
  } key_report_t;

  // Encoder result
  typedef struct packed {
    logic [2:0] row;
    logic [2:0] col;
    logic       shift;
    logic       ctrl;
    logic       alt;
  } key_info_t;

  // Reply byte view
  typedef struct packed {
    logic [7:0] reply;
    logic [7:0] pad;
  } reply_byte_t;

  // IPC return word, sent MSB first
  typedef union packed {
    key_report_t key;
    reply_byte_t rep;
  } ipc_ret_u;

endpackage

//--- verilog/port_decode.sv
`timescale 1ns/1ps
module port_decode (
  input  logic                  clk_cpu,
  input  logic                  reset,
  input  ql_bus_pkg::cpu_bus_t  i_bus,
  input  logic [31:0]           i_timer,        // Seconds counter
  input  logic [7:0]            i_irq_pending,  // Pending interrupts
  input  logic [7:0]            i_ipc_status,   // IPC status byte
  output ql_bus_pkg::port_sel_t o_sel,
  output logic [15:0]           o_rdata,
  output logic                  o_mode
);
  import ql_bus_pkg::*;

  logic bus_rd;  // Qualified read cycle
  logic bus_wr;  // Qualified write cycle

  assign bus_rd = i_bus.vma && i_bus.rw;
  assign bus_wr = i_bus.vma && !i_bus.rw;

  // ====================================================================
  // Address and strobe decode
  // ====================================================================
  always_comb begin
    // Timer spans two words
    o_sel.timer_rd  = bus_rd && (i_bus.addr[6:2] == PORT_TIMER[6:2]);
    // Even byte clears, odd byte adjusts
    o_sel.timer_clr = bus_wr && (i_bus.addr == PORT_TIMER) && !i_bus.uds_n;
    o_sel.timer_adj = bus_wr && (i_bus.addr == PORT_TIMER) && !i_bus.lds_n;
    o_sel.ipc_wr    = bus_wr && (i_bus.addr == PORT_IPC_WR) && !i_bus.lds_n;
    o_sel.irq_rd    = bus_rd && (i_bus.addr == PORT_IPC_IRQ);
    o_sel.irq_wr    = bus_wr && (i_bus.addr == PORT_IPC_IRQ) && !i_bus.lds_n;
    o_sel.mode_wr   = bus_wr && (i_bus.addr == PORT_DISPLAY);
  end

  // Display mode latch
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      o_mode <= 1'b1;  // 256x256 after reset
    end else if (o_sel.mode_wr) begin
      o_mode <= i_bus.wdata[3];
    end
  end

  // ====================================================================
  // Read data mux
  // ====================================================================
  always_comb begin
    if (o_sel.timer_rd) begin
      // Odd word holds low half
      o_rdata = i_bus.addr[1] ? i_timer[15:0] : i_timer[31:16];
    end else if (o_sel.irq_rd) begin
      o_rdata = {i_ipc_status, i_irq_pending};
    end else begin
      o_rdata = '0;
    end
  end

endmodule

//--- verilog/rtc_counter.sv
`timescale 1ns/1ps
module rtc_counter #(
  parameter int PRESCALE_DIV = 27000000  // Clocks per second
) (
  input  logic                  clk_cpu,
  input  ql_bus_pkg::port_sel_t i_sel,
  input  logic [7:0]            i_wdata,  // Adjust byte
  output logic [31:0]           o_timer
);

  localparam int               PRE_W    = (PRESCALE_DIV > 1) ? $clog2(PRESCALE_DIV) : 1;
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRESCALE_DIV - 1);

  logic [PRE_W-1:0] prescaler;
  logic             tick;       // Last cycle of the second
  logic [1:0]       byte_ptr;   // Next byte to adjust
  logic [31:0]      timer_nxt;

  assign tick = (prescaler == PRE_LAST);

  // Count plus optional byte load
  always_comb begin
    timer_nxt = o_timer + {31'd0, tick};
    if (i_sel.timer_adj) begin
      timer_nxt[{byte_ptr, 3'b000} +: 8] = i_wdata;  // Byte 0 lowest
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (i_sel.timer_clr) begin
      prescaler <= '0;  // Restart the second too
      o_timer   <= '0;
      byte_ptr  <= '0;
    end else begin
      prescaler <= tick ? '0 : prescaler + 1'b1;
      o_timer   <= timer_nxt;
      if (i_sel.timer_adj) begin
        byte_ptr <= byte_ptr + 2'd1;
      end
    end
  end

endmodule

//--- verilog/irq_ctrl.sv
`timescale 1ns/1ps
module irq_ctrl (
  input  logic                  clk_cpu,
  input  logic                  reset,
  input  ql_bus_pkg::port_sel_t i_sel,
  input  logic [4:0]            i_ack,        // Acknowledge bits
  input  logic                  i_vsync,
  input  logic                  i_timer_lsb,
  output logic [7:0]            o_pending,
  output logic                  o_ipl1_n
);

  logic vsync_q1;   // Sampled vsync
  logic vsync_q2;   // Previous sample
  logic vsync_irq;  // Frame interrupt flag

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_q1  <= 1'b0;
      vsync_q2  <= 1'b0;
      vsync_irq <= 1'b0;
    end else begin
      vsync_q1 <= i_vsync;
      vsync_q2 <= vsync_q1;
      if (i_sel.irq_wr && i_ack[3]) begin
        vsync_irq <= 1'b0;  // Ack wins over a new edge
      end else if (vsync_q2 && !vsync_q1) begin
        vsync_irq <= 1'b1;  // Falling edge
      end
    end
  end

  // Timer bit 5, vsync bit 3
  assign o_pending = {2'b00, i_timer_lsb, 1'b0, vsync_irq, 3'b000};
  assign o_ipl1_n  = !vsync_irq;

endmodule

//--- verilog/key_encoder.sv
`timescale 1ns/1ps
module key_encoder (
  input  logic [63:0]           i_matrix,    // One byte per row
  input  logic [2:0]            i_row_sel,   // Row asked for by IPC
  output ql_ipc_pkg::key_info_t o_key,
  output logic [7:0]            o_row_byte
);

  // Lowest set bit among 0 to 6, else 7
  function automatic logic [2:0] first_set(input logic [7:0] v);
    logic [2:0] idx;
    idx = 3'd7;
    for (int i = 6; i >= 0; i--) begin
      if (v[i]) idx = 3'(i);
    end
    return idx;
  endfunction

  logic [7:0] row_hit;   // Row has a key down
  logic [2:0] key_row;
  logic [7:0] key_byte;  // Byte of the found row

  always_comb begin
    for (int r = 0; r < 8; r++) begin
      row_hit[r] = |i_matrix[r*8 +: 8];
    end
  end

  assign key_row  = first_set(row_hit);
  assign key_byte = i_matrix[{key_row, 3'b000} +: 8];

  assign o_key.row   = key_row;
  assign o_key.col   = first_set(key_byte);
  assign o_key.shift = i_matrix[56];
  assign o_key.ctrl  = i_matrix[57];
  assign o_key.alt   = i_matrix[58];

  assign o_row_byte = i_matrix[{i_row_sel, 3'b000} +: 8];

endmodule

//--- verilog/ipc_fsm.sv
`timescale 1ns/1ps
module ipc_fsm (
  input  logic                              clk_cpu,
  input  logic                              reset,
  input  ql_bus_pkg::port_sel_t             i_sel,
  input  logic                              i_bit,        // Data bit 1
  input  logic                              i_zero,       // Data bit 0
  input  ql_ipc_pkg::key_info_t             i_key,
  input  logic [7:0]                        i_row_byte,
  input  logic                              i_key_strobe,
  input  logic                              i_key_down,
  output logic [2:0]                        o_row_sel,
  output logic [7:0]                        o_status,
  output logic [ql_ipc_pkg::SOUND_BITS-1:0] o_sound
);
  import ql_ipc_pkg::*;

  ipc_state_e state;
  logic       wr_q;         // Previous IPC strobe
  logic       wr_go;        // First cycle of a write
  logic [3:0] ipc_data;
  logic [3:0] ipc_shift;    // Data with new bit in
  logic [5:0] bit_cnt;
  logic [6:0] ipc_bits;     // Length of current transfer
  logic       last_bit;
  logic       key_pressed;  // Press since last status
  ipc_ret_u   ipc_ret;      // Reply shifter
  ipc_ret_u   key_word;
  ipc_ret_u   status_word;
  ipc_ret_u   row_word;

  assign wr_go     = i_sel.ipc_wr && !wr_q;
  assign ipc_shift = {ipc_data[2:0], i_bit};
  assign last_bit  = ({1'b0, bit_cnt} == ipc_bits - 7'd1);
  assign o_row_sel = ipc_shift[2:0];  // Row number from last param bits
  assign o_status  = {ipc_ret.rep.reply[7], 7'b0};  // Never busy

  // ====================================================================
  // Reply words
  // ====================================================================
  always_comb begin
    key_word           = '0;
    key_word.key.tag   = KEY_TAG;
    key_word.key.shift = i_key.shift;
    key_word.key.ctrl  = i_key.ctrl;
    key_word.key.alt   = i_key.alt;
    key_word.key.row_n = ~i_key.row;
    key_word.key.col   = i_key.col;
    status_word           = '0;
    status_word.rep.reply = {7'b0, key_pressed};
    row_word           = '0;
    row_word.rep.reply = i_row_byte;
  end

  // ====================================================================
  // Command engine
  // ====================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state       <= IPC_IDLE;
      wr_q        <= 1'b0;
      ipc_data    <= '0;
      bit_cnt     <= '0;
      ipc_bits    <= '0;
      key_pressed <= 1'b0;
      ipc_ret     <= '0;
    end else begin
      wr_q <= i_sel.ipc_wr;
      if (i_key_strobe && i_key_down) key_pressed <= 1'b1;
      if (wr_go) begin
        ipc_data <= ipc_shift;
        if (!i_zero) bit_cnt <= bit_cnt + 6'd1;  // Skip initial write of 1
        case (state)
          IPC_IDLE: begin
            if (bit_cnt[1:0] == 2'd3) begin  // Fourth command bit
              case (ipc_shift)
                CMD_STATUS: begin
                  state       <= IPC_SEND;
                  ipc_bits    <= 7'd8;
                  bit_cnt     <= '0;
                  ipc_ret     <= status_word;
                  key_pressed <= 1'b0;
                end
                CMD_READ_KEY: begin
                  state    <= IPC_SEND;
                  ipc_bits <= 7'd16;
                  bit_cnt  <= '0;
                  ipc_ret  <= key_word;
                end
                CMD_KEY_ROW: begin
                  state    <= IPC_PARAM;  // Row number follows
                  ipc_bits <= 7'd4;
                  bit_cnt  <= '0;
                end
                CMD_SET_SOUND: begin
                  state    <= IPC_SOUND;
                  ipc_bits <= 7'(SOUND_BITS);
                  bit_cnt  <= '0;
                end
                default: ;  // Other commands ignored
              endcase
            end
          end
          IPC_SEND: begin
            if (bit_cnt != '0) ipc_ret <= {ipc_ret[14:0], 1'b0};
            if (last_bit) begin
              state   <= IPC_IDLE;
              bit_cnt <= '0;
            end
          end
          IPC_PARAM: begin
            if (last_bit) begin
              state    <= IPC_SEND;
              bit_cnt  <= '0;
              ipc_bits <= 7'd8;
              ipc_ret  <= row_word;
            end
          end
          IPC_SOUND: begin
            if (last_bit) begin
              state   <= IPC_IDLE;
              bit_cnt <= '0;
            end
          end
          default: state <= IPC_IDLE;
        endcase
      end
    end
  end

  // Sound parameter shifter
  always_ff @(posedge clk_cpu) begin
    if (wr_go && state == IPC_SOUND) begin
      o_sound <= {o_sound[SOUND_BITS-2:0], i_bit};
    end
  end

endmodule

//--- verilog/ql_periph_top.sv
`timescale 1ns/1ps
module ql_periph_top #(
  parameter int PRESCALE_DIV = 27000000  // CPU clock in Hz
) (
  input  logic                              clk_cpu,
  input  logic                              reset,
  input  ql_bus_pkg::cpu_bus_t              i_bus,
  input  logic                              i_vsync,
  input  logic [63:0]                       i_kbd_matrix,
  input  logic                              i_key_strobe,  // Key event
  input  logic                              i_key_down,    // Event is a press
  output logic [15:0]                       o_rdata,
  output logic                              o_ipl1_n,
  output logic                              o_mode,
  output logic [ql_ipc_pkg::SOUND_BITS-1:0] o_sound
);
  import ql_bus_pkg::*;
  import ql_ipc_pkg::*;

  port_sel_t   sel;
  logic [31:0] timer;
  logic [7:0]  irq_pending;
  logic [7:0]  ipc_status;
  key_info_t   key_info;
  logic [7:0]  row_byte;
  logic [2:0]  row_sel;

  // ====================================================================
  // Bus side
  // ====================================================================
  port_decode u_port_decode (
    .clk_cpu       (clk_cpu),
    .reset         (reset),
    .i_bus         (i_bus),
    .i_timer       (timer),
    .i_irq_pending (irq_pending),
    .i_ipc_status  (ipc_status),
    .o_sel         (sel),
    .o_rdata       (o_rdata),
    .o_mode        (o_mode)
  );

  rtc_counter #(
    .PRESCALE_DIV (PRESCALE_DIV)
  ) u_rtc_counter (
    .clk_cpu (clk_cpu),
    .i_sel   (sel),
    .i_wdata (i_bus.wdata[7:0]),
    .o_timer (timer)
  );

  irq_ctrl u_irq_ctrl (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_sel       (sel),
    .i_ack       (i_bus.wdata[4:0]),
    .i_vsync     (i_vsync),
    .i_timer_lsb (timer[0]),
    .o_pending   (irq_pending),
    .o_ipl1_n    (o_ipl1_n)
  );

  // ====================================================================
  // Keyboard and IPC
  // ====================================================================
  key_encoder u_key_encoder (
    .i_matrix   (i_kbd_matrix),
    .i_row_sel  (row_sel),
    .o_key      (key_info),
    .o_row_byte (row_byte)
  );

  ipc_fsm u_ipc_fsm (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_sel        (sel),
    .i_bit        (i_bus.wdata[1]),
    .i_zero       (i_bus.wdata[0]),
    .i_key        (key_info),
    .i_row_byte   (row_byte),
    .i_key_strobe (i_key_strobe),
    .i_key_down   (i_key_down),
    .o_row_sel    (row_sel),
    .o_status     (ipc_status),
    .o_sound      (o_sound)
  );

endmodule

//--- sim/ql_periph_model.svh
`ifndef QL_PERIPH_MODEL_SVH
`define QL_PERIPH_MODEL_SVH

// ====================================================================
// Reference model of the peripheral block
// ====================================================================
logic exp_mode;         // Display mode latch
logic exp_vsync;        // Frame interrupt flag
logic exp_key_pressed;  // Press seen since last status

task automatic reset_model();
  exp_mode        = 1'b1;  // 256x256 after reset
  exp_vsync       = 1'b0;
  exp_key_pressed = 1'b0;
endtask

task automatic set_mode(input logic data_bit3);
  exp_mode = data_bit3;
endtask

task automatic raise_vsync();
  exp_vsync = 1'b1;  // Falling vsync edge
endtask

task automatic ack_vsync(input logic [7:0] data);
  if (data[3]) exp_vsync = 1'b0;
endtask

task automatic record_key_event(input logic down);
  if (down) exp_key_pressed = 1'b1;  // Releases do not count
endtask

// Status reply clears the press flag
task automatic take_status_reply(output logic [7:0] reply);
  reply           = {7'd0, exp_key_pressed};
  exp_key_pressed = 1'b0;
endtask

// Seconds passed since the clear edge
function automatic logic [31:0] predict_timer(input logic [31:0] start, input int cycles);
  return start + 32'(cycles / PRESCALE_DIV);
endfunction

function automatic logic [15:0] key_report_for(input logic [63:0] m);
  logic [2:0] row;
  logic [2:0] col;
  logic [7:0] row_bits;
  row = 3'd7;  // No key gives row 7
  for (int r = 7; r >= 0; r--) begin
    if (m[r*8 +: 8] != 8'h00) row = 3'(r);
  end
  row_bits = m[row*8 +: 8];
  col      = 3'd7;
  for (int c = 7; c >= 0; c--) begin
    if (row_bits[c]) col = 3'(c);
  end
  // Tag, shift/ctrl/alt, inverted row, column
  return {4'b0001, 1'b0, m[56], m[57], m[58], 2'b00, ~row, col};
endfunction

function automatic logic [7:0] row_byte_for(input logic [63:0] m, input int row);
  return m[row*8 +: 8];
endfunction

`endif

//--- sim/tb_ql_periph.sv
`timescale 1ns/1ps
module tb_ql_periph;
  import ql_bus_pkg::*;

  localparam int PRESCALE_DIV = 16;
  localparam int N_MODE   = 8;
  localparam int N_TIMER  = 4;
  localparam int N_VSYNC  = 6;
  localparam int N_KEY    = 6;
  localparam int N_ROW    = 6;
  localparam int N_STATUS = 4;
  localparam int N_SOUND  = 2;
  // Twice the worst case cycles of all tests
  localparam int MAX_CYCLES = 2 * (16 + N_MODE * 4 + N_TIMER * (20 + 4 * PRESCALE_DIV)
                                   + N_VSYNC * 32 + N_KEY * 74 + N_ROW * 48
                                   + N_STATUS * 48 + N_SOUND * 136);

  logic        clk_cpu;
  logic        reset;
  cpu_bus_t    bus;
  logic        vsync;
  logic [63:0] kbd_matrix;
  logic        key_strobe;
  logic        key_down;
  logic [15:0] rdata;
  logic        ipl1_n;
  logic        mode;
  logic [63:0] sound;
  logic [31:0] lcg_state;
  int          cycle_count = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          read_cycle;  // Cycle of last read sample

  `include "ql_periph_model.svh"

  ql_periph_top #(
    .PRESCALE_DIV (PRESCALE_DIV)
  ) i_ql_periph_top (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_bus        (bus),
    .i_vsync      (vsync),
    .i_kbd_matrix (kbd_matrix),
    .i_key_strobe (key_strobe),
    .i_key_down   (key_down),
    .o_rdata      (rdata),
    .o_ipl1_n     (ipl1_n),
    .o_mode       (mode),
    .o_sound      (sound)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #50 clk_cpu = ~clk_cpu;  // 10 MHz
  end

  always @(posedge clk_cpu) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= MAX_CYCLES);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ====================================================================
  // Helpers
  // ====================================================================
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Sparse matrix so rows and columns vary
  function automatic logic [63:0] random_matrix();
    logic [63:0] m;
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r           = next_random();
      m[i*8 +: 8] = (r[31:29] < 3'd4) ? 8'h00 : (r[27:20] & r[19:12]);
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_cpu);
  endtask

  task automatic idle_bus();
    bus       = '0;
    bus.uds_n = 1'b1;
    bus.lds_n = 1'b1;
  endtask

  // One write cycle followed by an idle cycle
  task automatic write_port(input logic [6:1] addr, input logic upper, input logic lower,
                            input logic [15:0] data);
    @(negedge clk_cpu);
    bus.vma   = 1'b1;
    bus.rw    = 1'b0;
    bus.uds_n = !upper;
    bus.lds_n = !lower;
    bus.addr  = addr;
    bus.wdata = data;
    @(negedge clk_cpu);
    idle_bus();
  endtask

  task automatic read_port(input logic [6:1] addr, output logic [15:0] data);
    @(negedge clk_cpu);
    bus.vma   = 1'b1;
    bus.rw    = 1'b1;
    bus.uds_n = 1'b0;
    bus.lds_n = 1'b0;
    bus.addr  = addr;
    @(negedge clk_cpu);
    data       = rdata;  // Stable between edges
    read_cycle = cycle_count;
    idle_bus();
  endtask

  // Bits go out MSB first on data bit 1
  task automatic send_ipc_bits(input logic [63:0] bits, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      write_port(PORT_IPC_WR, 1'b0, 1'b1, {14'd0, bits[i], 1'b0});
    end
  endtask

  task automatic read_ipc_reply(input int n, output logic [15:0] reply);
    logic [15:0] word;
    reply = '0;
    for (int i = 0; i < n; i++) begin
      write_port(PORT_IPC_WR, 1'b0, 1'b1, 16'h0000);  // Clock next bit out
      read_port(PORT_IPC_IRQ, word);
      reply = {reply[14:0], word[15]};                 // Status bit 7
    end
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    logic [15:0] word;
    logic [15:0] hi_word;
    logic [15:0] ack_data;
    logic [31:0] r;
    logic [31:0] value;
    logic [31:0] got;
    logic [31:0] expect_t;
    logic [63:0] bits;
    logic [7:0]  exp_byte;
    int          clr_cycle;
    int          row;

    lcg_state  = 32'h155c;
    reset      = 1'b1;
    vsync      = 1'b0;
    kbd_matrix = '0;
    key_strobe = 1'b0;
    key_down   = 1'b0;
    idle_bus();
    reset_model();
    repeat (8) @(negedge clk_cpu);
    reset = 1'b0;

    // Reset state and display mode
    check_value("o_mode", mode, exp_mode);
    check_value("o_ipl1_n", ipl1_n, 1'b1);
    write_port(PORT_TIMER, 1'b1, 1'b0, 16'h0000);  // Timer starts undefined
    read_port(PORT_IPC_IRQ, word);
    check_value("irq_port", word, 16'h0000);
    for (int m = 0; m < N_MODE; m++) begin
      r = next_random();
      write_port(PORT_DISPLAY, 1'b1, 1'b1, {12'd0, r[31], 3'd0});
      set_mode(r[31]);
      check_value("o_mode", mode, exp_mode);
    end

    // Timer clear, byte adjust and count
    for (int t = 0; t < N_TIMER; t++) begin
      write_port(PORT_TIMER, 1'b1, 1'b0, 16'h0000);
      clr_cycle = cycle_count;
      value     = next_random();
      for (int b = 0; b < 4; b++) begin
        write_port(PORT_TIMER, 1'b0, 1'b1, {8'h00, value[b*8 +: 8]});  // Byte 0 first
      end
      r = next_random();
      wait_cycles(PRESCALE_DIV * (1 + r[31:30]));
      read_port(6'd1, word);  // Low half
      read_port(6'd0, hi_word);
      got      = {hi_word, word};
      expect_t = predict_timer(value, read_cycle - clr_cycle);
      if (got == expect_t - 32'd1 || got == expect_t + 32'd1) expect_t = got;  // One second slack
      check_value("timer", got, expect_t);
      // Timer bit 0 shows as pending bit 5
      read_port(PORT_IPC_IRQ, word);
      expect_t = predict_timer(value, read_cycle - clr_cycle);
      check_value("pending_bit5", word[5], expect_t[0]);
    end

    // Vsync interrupt and acknowledge
    for (int v = 0; v < N_VSYNC; v++) begin
      r     = next_random();
      vsync = 1'b1;
      wait_cycles(1 + r[31:30]);
      vsync = 1'b0;
      raise_vsync();
      wait_cycles(3 + r[29:28]);
      read_port(PORT_IPC_IRQ, word);
      check_value("pending_bit3", word[3], exp_vsync);
      check_value("o_ipl1_n", ipl1_n, !exp_vsync);
      ack_data = r[15:0] & 16'h00f7;  // Bit 3 clear keeps the flag
      write_port(PORT_IPC_IRQ, 1'b0, 1'b1, ack_data);
      ack_vsync(ack_data[7:0]);
      wait_cycles(3);
      read_port(PORT_IPC_IRQ, word);
      check_value("pending_bit3", word[3], exp_vsync);
      check_value("o_ipl1_n", ipl1_n, !exp_vsync);
      ack_data = (r[15:0] & 16'h00f7) | 16'h0008;
      write_port(PORT_IPC_IRQ, 1'b0, 1'b1, ack_data);
      ack_vsync(ack_data[7:0]);
      wait_cycles(3);
      read_port(PORT_IPC_IRQ, word);
      check_value("pending_bit3", word[3], exp_vsync);
      check_value("o_ipl1_n", ipl1_n, !exp_vsync);
    end

    // Read key
    for (int k = 0; k < N_KEY; k++) begin
      kbd_matrix = random_matrix();
      send_ipc_bits(64'd8, 4);
      read_ipc_reply(16, word);
      check_value("key_report", word, key_report_for(kbd_matrix));
    end

    // Read key row with the row number after the command
    for (int k = 0; k < N_ROW; k++) begin
      kbd_matrix = random_matrix();
      r          = next_random();
      row        = r[31:29];
      send_ipc_bits(64'd9, 4);
      send_ipc_bits({60'd0, r[28], r[31:29]}, 4);
      read_ipc_reply(8, word);
      check_value("row_reply", word[7:0], row_byte_for(kbd_matrix, row));
    end

    // Status after key events
    for (int k = 0; k < N_STATUS; k++) begin
      r = next_random();
      for (int s = 0; s < r[31:30]; s++) begin
        key_strobe = 1'b1;
        key_down   = r[20 + s];
        record_key_event(key_down);
        @(negedge clk_cpu);
        key_strobe = 1'b0;
        key_down   = 1'b0;
      end
      send_ipc_bits(64'd1, 4);
      read_ipc_reply(8, word);
      take_status_reply(exp_byte);
      check_value("status_reply", word[7:0], exp_byte);
    end

    // Sound parameters
    for (int k = 0; k < N_SOUND; k++) begin
      bits = {next_random(), next_random()};
      send_ipc_bits(64'd10, 4);
      send_ipc_bits(bits, 64);
      check_value("o_sound", sound, bits);
    end

    $display("checks: %0d errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+sim
verilog/ql_bus_pkg.sv
verilog/ql_ipc_pkg.sv
verilog/port_decode.sv
verilog/rtc_counter.sv
verilog/irq_ctrl.sv
verilog/key_encoder.sv
verilog/ipc_fsm.sv
verilog/ql_periph_top.sv
sim/tb_ql_periph.sv

//--- Bender.yml
package:
  name: ql_periph

sources:
  - files:
      - verilog/ql_bus_pkg.sv
      - verilog/ql_ipc_pkg.sv
      - verilog/port_decode.sv
      - verilog/rtc_counter.sv
      - verilog/irq_ctrl.sv
      - verilog/key_encoder.sv
      - verilog/ipc_fsm.sv
      - verilog/ql_periph_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_ql_periph.sv
